/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - include
    files:
      - logic/exu_pkg.sv
      - logic/exu_alu_shift.sv
      - logic/exu_alu.sv
      - logic/exu_op_decode.sv
      - logic/exu_branch.sv
      - logic/exu_ctrl.sv
      - logic/exu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/exu_assertions.sv
      - verif/exu_checker.sv
      - verif/exu_tb.sv

/* exu.f */
+incdir+include
logic/exu_pkg.sv
logic/exu_alu_shift.sv
logic/exu_alu.sv
logic/exu_op_decode.sv
logic/exu_branch.sv
logic/exu_ctrl.sv
logic/exu_top.sv
verif/exu_assertions.sv
verif/exu_checker.sv
verif/exu_tb.sv

/* include/exu_params.svh */
/*
 * execute stage constants
 * data width, RV32I opcodes, funct3 codes and reset pc
 */
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN        32
`define EXU_RESET_PC    32'h8000_0000   // first fetch address

// major opcodes, inst[6:0]
`define EXU_OPC_OP      7'b0110011
`define EXU_OPC_OP_IMM  7'b0010011
`define EXU_OPC_LUI     7'b0110111
`define EXU_OPC_AUIPC   7'b0010111
`define EXU_OPC_JAL     7'b1101111
`define EXU_OPC_JALR    7'b1100111
`define EXU_OPC_BRANCH  7'b1100011

// funct3 for OP / OP-IMM
`define EXU_F3_ADD      3'b000          // add and sub share this
`define EXU_F3_SLL      3'b001
`define EXU_F3_SLT      3'b010
`define EXU_F3_SLTU     3'b011
`define EXU_F3_XOR      3'b100
`define EXU_F3_SRL      3'b101          // srl and sra share this
`define EXU_F3_OR       3'b110
`define EXU_F3_AND      3'b111

// funct3 for BRANCH
`define EXU_F3_BEQ      3'b000
`define EXU_F3_BNE      3'b001
`define EXU_F3_BLT      3'b100
`define EXU_F3_BGE      3'b101
`define EXU_F3_BLTU     3'b110
`define EXU_F3_BGEU     3'b111

`endif

/* logic/exu_alu.sv */
/*
 * integer ALU
 * shared add/sub with compare flags, logic ops, barrel shifter
 * and a db pass-through, all picked by a one-hot op
 */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu import exu_pkg::*; (
    input  word_t   da,
    input  word_t   db,
    input  alu_op_t op,
    output word_t   result,
    output logic    less,
    output logic    zero
);

    logic  do_sub;          // subtract for sub and both compares
    logic  unsigned_cmp;
    word_t db_x;            // db, inverted when subtracting
    word_t sum;
    logic  carry;
    logic  overflow;
    word_t shift_out;

    assign do_sub       = op[ALU_SUB] | op[ALU_SLT] | op[ALU_SLTU];
    assign unsigned_cmp = op[ALU_SLTU];

    // one adder, two's complement subtract through inversion plus carry-in
    assign db_x         = db ^ {`EXU_XLEN{do_sub}};
    assign {carry, sum} = {1'b0, da} + {1'b0, db_x} + {{`EXU_XLEN{1'b0}}, do_sub};

    // signed overflow when inputs agree in sign and sum does not
    assign overflow = (da[`EXU_XLEN-1] == db_x[`EXU_XLEN-1]) &&
                      (sum[`EXU_XLEN-1] != da[`EXU_XLEN-1]);

    // no carry out of da - db means borrow, so da < db unsigned
    assign less = unsigned_cmp ? ~carry : (overflow ^ sum[`EXU_XLEN-1]);
    assign zero = (sum == '0);

    exu_alu_shift u_shift (
        .din   (da),
        .shamt (db[4:0]),           // upper bits of db ignored
        .left  (op[ALU_SLL]),
        .arith (op[ALU_SRA]),
        .dout  (shift_out)
    );

    // and-or mux, op is one-hot so at most one term survives
    assign result = ({`EXU_XLEN{op[ALU_ADD]}}      & sum)             |
                    ({`EXU_XLEN{op[ALU_SUB]}}      & sum)             |
                    ({`EXU_XLEN{op[ALU_SLT]}}      & word_t'(less))   |
                    ({`EXU_XLEN{op[ALU_SLTU]}}     & word_t'(less))   |
                    ({`EXU_XLEN{op[ALU_OR]}}       & (da | db))       |
                    ({`EXU_XLEN{op[ALU_AND]}}      & (da & db))       |
                    ({`EXU_XLEN{op[ALU_XOR]}}      & (da ^ db))       |
                    ({`EXU_XLEN{op[ALU_SLL]}}      & shift_out)       |
                    ({`EXU_XLEN{op[ALU_SRL]}}      & shift_out)       |
                    ({`EXU_XLEN{op[ALU_SRA]}}      & shift_out)       |
                    ({`EXU_XLEN{op[ALU_EXPLICIT]}} & db);              // lui

endmodule

/* logic/exu_alu_shift.sv */
/*
 * barrel shifter
 * five log stages shifting right, left shifts reuse them by bit reversal
 */
`timescale 1ns/1ps

module exu_alu_shift import exu_pkg::*; (
    input  word_t  din,
    input  shamt_t shamt,
    input  logic   left,
    input  logic   arith,
    output word_t  dout
);

    function automatic word_t bit_rev(input word_t w);
        word_t r;
        for (int i = 0; i < $bits(word_t); i++) begin
            r[i] = w[$bits(word_t)-1-i];
        end
        return r;
    endfunction

    word_t s0, s1, s2, s3, s4, s5;
    logic  fill;                                // bit shifted in from the top

    assign fill = arith & din[$bits(word_t)-1]; // sign for sra, else zero
    assign s0   = left ? bit_rev(din) : din;

    assign s1 = shamt[0] ? {fill, s0[31:1]}        : s0;
    assign s2 = shamt[1] ? {{2{fill}}, s1[31:2]}   : s1;
    assign s3 = shamt[2] ? {{4{fill}}, s2[31:4]}   : s2;
    assign s4 = shamt[3] ? {{8{fill}}, s3[31:8]}   : s3;
    assign s5 = shamt[4] ? {{16{fill}}, s4[31:16]} : s4;

    assign dout = left ? bit_rev(s5) : s5;      // undo reversal for sll

endmodule

/* logic/exu_branch.sv */
/*
 * branch unit
 * resolves conditional branches from the ALU flags and
 * computes the redirect target for branches, jal and jalr
 */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_branch import exu_pkg::*; (
    input  word_t   pc,
    input  word_t   rs1,
    input  word_t   imm,
    input  funct3_t funct3,
    input  logic    is_branch,
    input  logic    is_jump,
    input  logic    jalr,
    input  logic    less,
    input  logic    zero,
    output logic    taken,
    output word_t   target
);

    logic  cond;            // branch compare holds
    word_t jalr_sum;

    always_comb begin
        case (funct3)
            `EXU_F3_BEQ:  cond = zero;
            `EXU_F3_BNE:  cond = ~zero;
            `EXU_F3_BLT:  cond = less;     // signed flag from slt
            `EXU_F3_BGE:  cond = ~less;
            `EXU_F3_BLTU: cond = less;     // unsigned flag from sltu
            `EXU_F3_BGEU: cond = ~less;
            default:      cond = 1'b0;     // 010 and 011 undefined
        endcase
    end

    assign taken = is_jump | (is_branch & cond);

    // jalr drops bit 0 of the sum
    assign jalr_sum = rs1 + imm;
    assign target   = jalr ? {jalr_sum[`EXU_XLEN-1:1], 1'b0} : (pc + imm);

endmodule

/* logic/exu_ctrl.sv */
/*
 * stage control
 * registers results on the issue strobe, pulses the result strobe
 * one cycle later and kills the instruction behind a taken redirect
 */
`timescale 1ns/1ps

module exu_ctrl import exu_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  in_valid,
    input  word_t result,
    input  logic  writes_rd,
    input  logic  taken,
    input  word_t target,
    output logic  out_valid,
    output word_t out_result,
    output logic  out_wen,
    output logic  out_redirect,
    output word_t out_target,
    output logic  out_kill
);

    exu_state_e state;
    logic       kill;       // current issue sits in the fetch shadow

    assign kill = (state == EXU_SHADOW);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= EXU_RUN;
            out_valid    <= 1'b0;
            out_wen      <= 1'b0;
            out_redirect <= 1'b0;
            out_kill     <= 1'b0;
        end else begin
            out_valid <= in_valid;                      // one cycle latency
            if (in_valid) begin
                out_wen      <= writes_rd & ~kill;
                out_redirect <= taken & ~kill;
                out_kill     <= kill;
                // killed instructions never open a new shadow
                state        <= (taken && !kill) ? EXU_SHADOW : EXU_RUN;
            end
        end
    end

    // payload, held until the next issue
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_result <= result;
            out_target <= target;
        end
    end

endmodule

/* logic/exu_op_decode.sv */
/*
 * operation decode
 * maps opcode, funct3 and funct7[5] onto a one-hot ALU op,
 * flags branches and jumps and muxes the ALU operands
 */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_op_decode import exu_pkg::*; (
    input  word_t   pc,
    input  word_t   rs1,
    input  word_t   rs2,
    input  word_t   imm,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  logic    funct7_5,
    output alu_op_t alu_op,
    output word_t   alu_da,
    output word_t   alu_db,
    output logic    is_branch,
    output logic    is_jump,
    output logic    is_jalr,
    output logic    writes_rd
);

    always_comb begin
        // defaults give a dead instruction
        alu_op    = '0;
        alu_da    = rs1;
        alu_db    = rs2;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_jalr   = 1'b0;
        writes_rd = 1'b0;

        case (opcode)
            `EXU_OPC_OP, `EXU_OPC_OP_IMM: begin
                writes_rd = 1'b1;
                if (opcode == `EXU_OPC_OP_IMM) begin
                    alu_db = imm;                   // shamt sits in imm[4:0]
                end
                case (funct3)
                    `EXU_F3_ADD: begin
                        // sub only exists in register form
                        if (opcode == `EXU_OPC_OP && funct7_5) begin
                            alu_op[ALU_SUB] = 1'b1;
                        end else begin
                            alu_op[ALU_ADD] = 1'b1;
                        end
                    end
                    `EXU_F3_SLL:  alu_op[ALU_SLL]  = 1'b1;
                    `EXU_F3_SLT:  alu_op[ALU_SLT]  = 1'b1;
                    `EXU_F3_SLTU: alu_op[ALU_SLTU] = 1'b1;
                    `EXU_F3_XOR:  alu_op[ALU_XOR]  = 1'b1;
                    `EXU_F3_SRL: begin
                        if (funct7_5) begin
                            alu_op[ALU_SRA] = 1'b1;  // arithmetic
                        end else begin
                            alu_op[ALU_SRL] = 1'b1;
                        end
                    end
                    `EXU_F3_OR:   alu_op[ALU_OR]   = 1'b1;
                    default:      alu_op[ALU_AND]  = 1'b1;
                endcase
            end
            `EXU_OPC_BRANCH: begin
                is_branch = 1'b1;                   // rs1 against rs2, no write
                case (funct3)
                    `EXU_F3_BLT, `EXU_F3_BGE:   alu_op[ALU_SLT]  = 1'b1;
                    `EXU_F3_BLTU, `EXU_F3_BGEU: alu_op[ALU_SLTU] = 1'b1;
                    default:                    alu_op[ALU_SUB]  = 1'b1; // eq/ne via zero
                endcase
            end
            `EXU_OPC_LUI: begin
                writes_rd              = 1'b1;
                alu_op[ALU_EXPLICIT]   = 1'b1;
                alu_db                 = imm;       // upper immediate as is
            end
            `EXU_OPC_AUIPC: begin
                writes_rd       = 1'b1;
                alu_op[ALU_ADD] = 1'b1;
                alu_da          = pc;
                alu_db          = imm;
            end
            `EXU_OPC_JAL, `EXU_OPC_JALR: begin
                writes_rd       = 1'b1;
                is_jump         = 1'b1;
                is_jalr         = (opcode == `EXU_OPC_JALR);
                alu_op[ALU_ADD] = 1'b1;             // link value pc + 4
                alu_da          = pc;
                alu_db          = word_t'(4);
            end
            default: ;                              // unsupported, no write
        endcase
    end

endmodule

/* logic/exu_pkg.sv */
/*
 * execute stage types
 * data words, instruction fields, one-hot ALU op and control state
 */
`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] word_t;    // operand, result, pc, target
    typedef logic [6:0]           opcode_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [4:0]           shamt_t;   // RV32 shift amount

    // bit positions inside the one-hot ALU operation
    localparam int unsigned ALU_ADD      = 0;
    localparam int unsigned ALU_SUB      = 1;
    localparam int unsigned ALU_SLT      = 2;
    localparam int unsigned ALU_SLTU     = 3;
    localparam int unsigned ALU_OR       = 4;
    localparam int unsigned ALU_AND      = 5;
    localparam int unsigned ALU_XOR      = 6;
    localparam int unsigned ALU_SLL      = 7;
    localparam int unsigned ALU_SRL      = 8;
    localparam int unsigned ALU_SRA      = 9;
    localparam int unsigned ALU_EXPLICIT = 10;   // pass db straight through
    localparam int unsigned ALU_NUM      = 11;

    typedef logic [ALU_NUM-1:0] alu_op_t;        // all zero means no op

    // squash tracking
    typedef enum logic {
        EXU_RUN,        // normal issue
        EXU_SHADOW      // next accepted instruction is killed
    } exu_state_e;

endpackage

/* logic/exu_top.sv */
/*
 * execute stage top
 * decode, ALU, branch unit and control for one RV32I instruction per strobe
 */
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  word_t   in_pc,
    input  word_t   in_rs1,
    input  word_t   in_rs2,
    input  word_t   in_imm,
    input  opcode_t in_opcode,
    input  funct3_t in_funct3,
    input  logic    in_funct7_5,
    output logic    out_valid,
    output word_t   out_result,
    output logic    out_wen,
    output logic    out_redirect,
    output word_t   out_target,
    output logic    out_kill
);

    alu_op_t alu_op;
    word_t   alu_da;
    word_t   alu_db;
    word_t   alu_out;
    logic    alu_less;
    logic    alu_zero;
    logic    is_branch;
    logic    is_jump;
    logic    is_jalr;
    logic    writes_rd;
    logic    taken;
    word_t   target;

    exu_op_decode u_decode (
        .pc        (in_pc),
        .rs1       (in_rs1),
        .rs2       (in_rs2),
        .imm       (in_imm),
        .opcode    (in_opcode),
        .funct3    (in_funct3),
        .funct7_5  (in_funct7_5),
        .alu_op    (alu_op),
        .alu_da    (alu_da),
        .alu_db    (alu_db),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .is_jalr   (is_jalr),
        .writes_rd (writes_rd)
    );

    exu_alu u_alu (
        .da     (alu_da),
        .db     (alu_db),
        .op     (alu_op),
        .result (alu_out),
        .less   (alu_less),
        .zero   (alu_zero)
    );

    exu_branch u_branch (
        .pc        (in_pc),
        .rs1       (in_rs1),
        .imm       (in_imm),
        .funct3    (in_funct3),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .jalr      (is_jalr),
        .less      (alu_less),
        .zero      (alu_zero),
        .taken     (taken),
        .target    (target)
    );

    exu_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .result       (alu_out),
        .writes_rd    (writes_rd),
        .taken        (taken),
        .target       (target),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_wen      (out_wen),
        .out_redirect (out_redirect),
        .out_target   (out_target),
        .out_kill     (out_kill)
    );

endmodule

/* verif/exu_assertions.sv */
/*
 * control assertions, bound into exu_ctrl
 * strobe timing, kill gating and squash state entry
 */
`timescale 1ns/1ps

module exu_assertions import exu_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       in_valid,
    input logic       taken,
    input logic       out_valid,
    input logic       out_wen,
    input logic       out_redirect,
    input logic       out_kill,
    input exu_state_e state
);

    int assert_fails = 0;       // tally for the end of run report

    // result strobe exactly one cycle after each issue
    strobe_follows: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid))
        else begin
            $error("out_valid does not match in_valid of the previous cycle");
            assert_fails++;
        end

    kill_gates: assert property (@(posedge clk) disable iff (!arst_n)
        out_kill |-> !out_wen && !out_redirect)
        else begin
            $error("killed instruction still writes or redirects");
            assert_fails++;
        end

    // shadow opens only on a taken, unkilled issue
    shadow_entry: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(state == EXU_SHADOW) |-> $past(in_valid && taken) && out_redirect && !out_kill)
        else begin
            $error("shadow state entered without a taken redirect");
            assert_fails++;
        end

endmodule

/* verif/exu_checker.sv */
/*
 * execute stage checker
 * reference model of the RV32I ops, branches and squash rule,
 * queues each issue and compares it at the result strobe
 */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_checker import exu_pkg::*; (
    input  logic    clk, arst_n, in_valid,
    input  word_t   in_pc, in_rs1, in_rs2, in_imm,
    input  opcode_t in_opcode,
    input  funct3_t in_funct3,
    input  logic    in_funct7_5,
    input  logic    out_valid, out_wen, out_redirect, out_kill,
    input  word_t   out_result, out_target,
    output int      err_count, chk_count, pending
);

    typedef struct packed {
        word_t result;
        word_t target;
        logic  wen;
        logic  redirect;
        logic  kill;
        logic  has_target;      // branch or jump
    } expect_t;

    expect_t exp_q[$];          // issued, strobe still due
    logic    shadow;            // model squash state
    logic    seen_issue;

    function automatic expect_t predict(word_t pc, word_t rs1, word_t rs2, word_t imm,
                                        opcode_t opc, funct3_t f3, logic f7);
        expect_t e;
        word_t   b;
        e = '0;
        b = (opc == `EXU_OPC_OP) ? rs2 : imm;   // register or immediate form
        case (opc)
            `EXU_OPC_OP, `EXU_OPC_OP_IMM: begin
                e.wen = 1'b1;
                case (f3)
                    `EXU_F3_ADD:  e.result = (opc == `EXU_OPC_OP && f7) ? rs1 - b : rs1 + b;
                    `EXU_F3_SLL:  e.result = rs1 << b[4:0];
                    `EXU_F3_SLT:  e.result = word_t'($signed(rs1) < $signed(b));
                    `EXU_F3_SLTU: e.result = word_t'(rs1 < b);
                    `EXU_F3_XOR:  e.result = rs1 ^ b;
                    `EXU_F3_SRL:  e.result = f7 ? word_t'($signed(rs1) >>> b[4:0]) : rs1 >> b[4:0];
                    `EXU_F3_OR:   e.result = rs1 | b;
                    default:      e.result = rs1 & b;
                endcase
            end
            `EXU_OPC_LUI: begin
                e.wen    = 1'b1;
                e.result = imm;
            end
            `EXU_OPC_AUIPC: begin
                e.wen    = 1'b1;
                e.result = pc + imm;
            end
            `EXU_OPC_JAL, `EXU_OPC_JALR: begin
                e.wen        = 1'b1;
                e.redirect   = 1'b1;                // always taken
                e.has_target = 1'b1;
                e.result     = pc + 32'd4;          // link
                e.target     = (opc == `EXU_OPC_JALR) ? ((rs1 + imm) & ~32'h1) : pc + imm;
            end
            `EXU_OPC_BRANCH: begin
                e.has_target = 1'b1;
                e.target     = pc + imm;
                case (f3)
                    `EXU_F3_BEQ:  e.redirect = (rs1 == rs2);
                    `EXU_F3_BNE:  e.redirect = (rs1 != rs2);
                    `EXU_F3_BLT:  e.redirect = ($signed(rs1) < $signed(rs2));
                    `EXU_F3_BGE:  e.redirect = ($signed(rs1) >= $signed(rs2));
                    `EXU_F3_BLTU: e.redirect = (rs1 < rs2);
                    `EXU_F3_BGEU: e.redirect = (rs1 >= rs2);
                    default:      e.redirect = 1'b0;   // undefined compare
                endcase
            end
            default: ;                              // unsupported, nothing happens
        endcase
        return e;
    endfunction

    task automatic report_mismatch(input string what, input word_t got, input word_t exp);
        $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
        err_count++;
    endtask

    task automatic compare_strobe(input expect_t e);
        chk_count++;
        if (out_kill !== e.kill) report_mismatch("out_kill", word_t'(out_kill), word_t'(e.kill));
        if (out_wen !== e.wen) report_mismatch("out_wen", word_t'(out_wen), word_t'(e.wen));
        if (out_redirect !== e.redirect)
            report_mismatch("out_redirect", word_t'(out_redirect), word_t'(e.redirect));
        // payload only matters when it is used
        if (e.wen && out_result !== e.result) report_mismatch("out_result", out_result, e.result);
        if (e.has_target && !e.kill && out_target !== e.target)
            report_mismatch("out_target", out_target, e.target);
    endtask

    initial begin
        err_count = 0;
        chk_count = 0;
        pending   = 0;
    end

    always @(posedge clk) begin : watch
        expect_t e;
        // control outputs low from reset until the first result
        if ((!arst_n || !seen_issue) && (out_valid || out_wen || out_redirect || out_kill)) begin
            $display("FAILED %0t: control output high before the first instruction", $time);
            err_count++;
        end
        if (!arst_n) begin
            exp_q.delete();
            shadow     = 1'b0;
            seen_issue = 1'b0;
        end else begin
            if (out_valid && exp_q.size() == 0) begin
                $display("extra result strobe at %0t with no instruction issued before it", $time);
                err_count++;
            end else if (out_valid) begin
                compare_strobe(exp_q.pop_front());
            end else if (exp_q.size() != 0) begin
                $display("missing result strobe at %0t for an issued instruction", $time);
                err_count++;
                exp_q.delete();
            end
            if (in_valid) begin
                e = predict(in_pc, in_rs1, in_rs2, in_imm, in_opcode, in_funct3, in_funct7_5);
                if (shadow) begin
                    e.kill     = 1'b1;              // sits behind a taken redirect
                    e.wen      = 1'b0;
                    e.redirect = 1'b0;
                end
                shadow     = e.redirect;            // killed ones never chain
                seen_issue = 1'b1;
                exp_q.push_back(e);
            end
        end
        pending = exp_q.size();
    end

endmodule

/* verif/exu_tb.sv */
/*
 * execute stage testbench
 * seeded random RV32I stream in four tests of 500 instructions,
 * exu_checker compares the results, exu_assertions watches control
 */
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_tb import exu_pkg::*; ();

    localparam int N_TESTS     = 4;
    localparam int N_PER_TEST  = 500;
    localparam int RST_CYCLES  = 10;
    localparam int MAX_CYCLES  = 4;                 // one issue plus up to three idle
    localparam int WATCHDOG_NS = (N_TESTS * N_PER_TEST * MAX_CYCLES + RST_CYCLES + 200) * 20;

    // seven supported opcodes, then a load as the unsupported one
    localparam opcode_t ALL_OPC [8] = '{`EXU_OPC_OP, `EXU_OPC_OP_IMM, `EXU_OPC_LUI,
        `EXU_OPC_AUIPC, `EXU_OPC_JAL, `EXU_OPC_JALR, `EXU_OPC_BRANCH, 7'b0000011};

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    word_t   in_pc, in_rs1, in_rs2, in_imm;
    opcode_t in_opcode;
    funct3_t in_funct3;
    logic    in_funct7_5;
    logic    out_valid, out_wen, out_redirect, out_kill;
    word_t   out_result, out_target;
    int      err_count, chk_count, pending;     // from the checker
    string   test_names [N_TESTS] = '{"alu ops", "lui auipc jumps", "branches", "mixed"};

    always #10 clk = ~clk;                      // 20 ns period

    exu_top     u_dut (.*);
    exu_checker u_checker (.*);
    bind exu_ctrl exu_assertions u_assertions (.*);

    // extremes and zero show up often
    function automatic word_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return 32'h8000_0000;
            2:       return 32'h7fff_ffff;
            3:       return 32'hffff_ffff;
            4:       return 32'h1;
            default: return $urandom();
        endcase
    endfunction

    function automatic opcode_t pick_opcode(input int test);
        int unsigned r;
        r = $urandom_range(0, 7);
        case (test)
            0:       return ALL_OPC[r % 2];                             // register and imm ALU
            1:       return ALL_OPC[2 + r % 4];                         // lui, auipc, jal, jalr
            2:       return (r < 6) ? ALL_OPC[6] : ALL_OPC[4 + r % 2];  // branches, some jumps
            default: return ALL_OPC[r];
        endcase
    endfunction

    task automatic issue_instr(input int test);
        word_t       a;
        int unsigned gap;
        a   = pick_operand();
        gap = $urandom_range(0, 7);
        gap = (gap < 4) ? 0 : gap - 4;          // mostly back-to-back
        @(posedge clk);
        in_valid    <= 1'b1;
        in_opcode   <= pick_opcode(test);
        in_funct3   <= funct3_t'($urandom_range(0, 7));
        in_funct7_5 <= 1'($urandom_range(0, 1));
        in_pc       <= `EXU_RESET_PC + ($urandom_range(0, 16383) << 2);
        in_rs1      <= a;
        in_rs2      <= ($urandom_range(0, 3) == 0) ? a : pick_operand();  // equal operands
        in_imm      <= pick_operand();
        repeat (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    initial begin
        int errs_before;
        int chks_before;
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_pc       = '0;
        in_rs1      = '0;
        in_rs2      = '0;
        in_imm      = '0;
        in_opcode   = '0;
        in_funct3   = '0;
        in_funct7_5 = 1'b0;
        void'($urandom(32'h523a));
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            errs_before = err_count;
            chks_before = chk_count;
            repeat (N_PER_TEST) issue_instr(t);
            @(posedge clk);
            in_valid <= 1'b0;
            @(negedge clk);
            while (pending != 0) @(negedge clk);    // last result compared
            $display("test %0d %-16s %0d results, %0d errors, %s", t, test_names[t],
                     chk_count - chks_before, err_count - errs_before,
                     (err_count == errs_before) ? "ok" : "BAD");
        end
        $display("totals: %0d results checked, %0d mismatches, %0d assertion errors",
                 chk_count, err_count, u_dut.u_ctrl.u_assertions.assert_fails);
        if (err_count == 0 && u_dut.u_ctrl.u_assertions.assert_fails == 0 &&
            chk_count == N_TESTS * N_PER_TEST) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // stage hung or strobes lost
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule
